// ==== list.f ====
+incdir+source
source/rv_pkg.sv
source/rv_stage_if.sv
source/rv_predecode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_pc_ctrl.sv
source/rv_core.sv
bench/rv_ref_model.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rv_core_tb -o rv_core_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/rv_core_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

// ==== bench/rv_core_tb.sv ====
// testbench for rv_core with a random program, rom and ram, random halt and store checks
`timescale 1ns/1ps

module rv_core_tb;

    localparam int LIMIT = 200 * 3 * 2 + 200; // cycles before the run is abandoned

    logic        CLK;
    logic        arst_n;
    logic        halt = 1'b0;
    logic [31:0] idata = '0;
    logic [31:0] datai;
    logic [31:0] iaddr, datao, daddr;
    logic [3:0]  be;
    logic        wr, rd, idle;
    logic [31:0] fetch_addr = '0;  // iaddr seen at the last rising edge
    logic [31:0] ram [64];         // data region at 0x400
    int          seed = 42;
    int          cycles = 0;

    rv_core dut_i (.*);

    assign datai = rd ? ram[daddr[7:2]] : '0; // combinational read under rd only

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic int rnd(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // picks x1 or x3..x15 so x2 keeps the stack pointer
    function automatic int pick_reg();
        int r;
        r = rnd(14);
        return (r == 0) ? 1 : r + 2;
    endfunction

    function automatic int align(input int off, input int f3);
        return off & ~((1 << (f3 % 4)) - 1);
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd_i, opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd_i[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd_i);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd_i[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, rd_i);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd_i[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, rd_i, opc);
        return {imm[19:0], rd_i[4:0], opc[6:0]};
    endfunction

    task automatic build_program();
        int i, k, kind, f3, imm, skip;
        for (i = 0; i < 1024; i++)
            rv_ref_model::prog[i[9:0]] = 32'h0000_006f; // jump to itself
        for (i = 0; i < 200; i++)
        begin
            kind = rnd(10);
            f3   = rnd(8);
            imm  = rnd(4096);
            skip = rnd(3) + 1;  // shadow length for branch and jal
            if (i + skip > 199)
                skip = 199 - i; // lands no later than the register dump
            case (kind)
                0, 1, 2:
                begin
                    if (f3 == 1)
                        imm = rnd(32);                   // slli
                    else if (f3 == 5)
                        imm = rnd(32) + 1024 * rnd(2);   // srli or srai
                    rv_ref_model::prog[i[9:0]] = enc_i(imm, pick_reg(), f3, pick_reg(), 32'h13);
                end
                3, 4:
                    rv_ref_model::prog[i[9:0]] = enc_r((f3 == 0 || f3 == 5) ? 32 * rnd(2) : 0,
                                                       pick_reg(), pick_reg(), f3, pick_reg());
                5:
                    rv_ref_model::prog[i[9:0]] = enc_u(rnd(1 << 20), pick_reg(),
                                                       rnd(2) ? 32'h37 : 32'h17);
                6:
                begin
                    f3 = rnd(5);
                    f3 = (f3 < 3) ? f3 : f3 + 1;       // lb lh lw lbu lhu
                    rv_ref_model::prog[i[9:0]] = enc_i(1024 + align(rnd(256), f3), 0, f3,
                                                       pick_reg(), 32'h03);
                end
                7:
                begin
                    f3 = rnd(3);
                    rv_ref_model::prog[i[9:0]] = enc_s(1024 + align(rnd(256), f3),
                                                       pick_reg(), 0, f3);
                end
                8:
                begin
                    f3 = rnd(6);
                    f3 = (f3 < 2) ? f3 : f3 + 2;
                    rv_ref_model::prog[i[9:0]] = enc_b(4 * (skip + 1), pick_reg(), pick_reg(), f3);
                end
                default:
                    rv_ref_model::prog[i[9:0]] = enc_j(4 * (skip + 1), pick_reg());
            endcase
        end
        // register dump of x0 to x31
        for (i = 0; i < 32; i++)
        begin
            k = 200 + i;
            rv_ref_model::prog[k[9:0]] = enc_s(1024 + 4 * i, i, 0, 2);
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, exp);
        if (got !== exp)
        begin
            $display("** Error (%0t): %s is %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // rom answers one clock after iaddr
    always @(posedge CLK)
        fetch_addr <= iaddr;

    always @(negedge CLK)
    begin
        idata <= rv_ref_model::prog[fetch_addr[11:2]];
        if (!arst_n)
            halt <= 1'b0;
        else
            halt <= (rnd(5) == 0);  // about one cycle in five
    end

    always @(posedge CLK)
    begin
        rv_ref_model::store_t exp;
        logic [31:0] mask;
        int k;
        if (!arst_n)
        begin
            for (k = 0; k < 64; k++)
                ram[k[5:0]] <= rv_ref_model::mem_fill(32'h400 + 4 * k);
        end
        else if (wr && !halt)
        begin
            if (rv_ref_model::exp_q.size() == 0)
            begin
                $display("test failed");
                $fatal(1, "store to %h after the model ran out of stores", daddr);
            end
            exp = rv_ref_model::exp_q.pop_front();
            check_eq("daddr", daddr, exp.addr);
            check_eq("be", {28'b0, be}, {28'b0, exp.be});
            check_eq("datao", datao, exp.data);
            mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
            ram[daddr[7:2]] <= (ram[daddr[7:2]] & ~mask) | (datao & mask);
        end
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("test failed");
            $fatal(1, "timeout with %0d stores still expected", rv_ref_model::exp_q.size());
        end
    end

    initial
    begin
        arst_n = 1'b0;
        build_program();
        rv_ref_model::run_model();
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        while (rv_ref_model::exp_q.size() != 0)
            @(posedge CLK);
        repeat (20) @(posedge CLK);  // room for a stray store
        $display("test passed");
        $finish;
    end

endmodule

// ==== bench/rv_core_props.sv ====
// bus and reset assertions, bound into every rv_core instance
`timescale 1ns/1ps

module rv_core_props (
    input logic       CLK,
    input logic       arst_n,
    input logic       wr,
    input logic       rd,
    input logic       in_reset,
    input logic       idle,
    input logic [3:0] be
);

    // a slot is either a load or a store
    a_wr_rd_excl: assert property (@(posedge CLK) disable iff (!arst_n) !(wr && rd))
        else $error("wr and rd high in the same cycle");

    a_wr_be: assert property (@(posedge CLK) disable iff (!arst_n) wr |-> be != 4'b0000)
        else $error("store with no byte enable");

    // reset count slots are flushed
    a_reset_idle: assert property (@(posedge CLK) disable iff (!arst_n) in_reset |-> idle)
        else $error("idle low during the reset sequence");

endmodule

bind rv_core rv_core_props props_i (.*);

// ==== bench/rv_ref_model.sv ====
// instruction-set model of the core that runs the program in prog and queues the stores it expects
`include "rv_macros.svh"

package rv_ref_model;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;   // lane-placed with unused lanes zero
        logic [3:0]  be;
    } store_t;

    logic [31:0] prog [1024]; // program image that the testbench rom also serves
    store_t      exp_q [$];   // stores in program order

    // start value of every data word from its full address
    function automatic logic [31:0] mem_fill(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt, is_reg,
                                        input logic [31:0] a, b);
        case (f3)
            3'd0: return (is_reg && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5:
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_cond(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] mem [64];   // 256-byte data region at 0x400
        logic [31:0] pc, npc, w, a, v, d, wbv, immi, r1, r2, mask;
        logic [3:0]  bev;
        logic        wen;
        int          k, steps, n;
        for (k = 0; k < 32; k++)
            x[k[4:0]] = '0;
        x[2] = `RV_RESET_SP;
        for (k = 0; k < 64; k++)
            mem[k[5:0]] = mem_fill(32'h400 + 4 * k);
        exp_q.delete();
        pc = `RV_RESET_PC;
        // stops at the jump to itself
        for (steps = 0; steps < 4000 && prog[pc[11:2]] != 32'h6f; steps++)
        begin
            w    = prog[pc[11:2]];
            r1   = x[w[19:15]];
            r2   = x[w[24:20]];
            immi = {{20{w[31]}}, w[31:20]};
            npc  = pc + 32'd4;
            wen  = 1'b1;
            wbv  = '0;
            case (w[6:0])
                7'h37: wbv = {w[31:12], 12'b0};      // lui
                7'h17: wbv = pc + {w[31:12], 12'b0}; // auipc
                7'h6f:
                begin
                    wbv = pc + 32'd4;
                    npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                7'h67:
                begin
                    wbv = pc + 32'd4;
                    npc = (r1 + immi) & ~32'd1;
                end
                7'h63:
                begin
                    wen = 1'b0;
                    if (br_cond(w[14:12], r1, r2))
                        npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                7'h03:
                begin
                    a = r1 + immi;
                    v = mem[a[7:2]] >> {a[1:0], 3'b000};
                    case (w[14:12])
                        3'd0: wbv = {{24{v[7]}}, v[7:0]};
                        3'd1: wbv = {{16{v[15]}}, v[15:0]};
                        3'd4: wbv = {24'b0, v[7:0]};
                        3'd5: wbv = {16'b0, v[15:0]};
                        default: wbv = v;
                    endcase
                end
                7'h23:
                begin
                    wen  = 1'b0;
                    a    = r1 + {{20{w[31]}}, w[31:25], w[11:7]};
                    n    = 1 << w[13:12];                    // bytes in the access
                    bev  = 4'(((1 << n) - 1) << a[1:0]);
                    mask = {{8{bev[3]}}, {8{bev[2]}}, {8{bev[1]}}, {8{bev[0]}}};
                    d    = (r2 << {a[1:0], 3'b000}) & mask;  // rs2 moved up to its lanes
                    mem[a[7:2]] = (mem[a[7:2]] & ~mask) | d;
                    exp_q.push_back('{addr: a, data: d, be: bev});
                end
                7'h13: wbv = alu(w[14:12], w[30], 1'b0, r1, immi);
                default: wbv = alu(w[14:12], w[30], 1'b1, r1, r2);
            endcase
            if (wen && w[11:7] != 5'd0)
                x[w[11:7]] = wbv;
            pc = npc;
        end
    endtask

endpackage

// ==== source/rv_core.sv ====
// two-stage RV32I core top level: stage instances, their wiring and the plain instruction/data bus
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       halt,   // freezes the core while the bus waits
    input  word_t      idata,  // rom word, one clock after iaddr
    input  word_t      datai,  // ram read data, combinational
    output word_t      iaddr,
    output word_t      datao,
    output word_t      daddr,
    output logic [3:0] be,
    output logic       wr,
    output logic       rd,
    output logic       idle    // flushed or reset slot
);

    logic  in_reset;
    logic  branch_taken;
    logic  wb_en;
    word_t wb_data;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    word_t load_data;

    rv_stage_if st_if ();  // decoded slot

    rv_predecode u_predecode (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .halt     (halt),
        .in_reset (in_reset),
        .idata    (idata),
        .st       (st_if)
    );

    rv_regfile u_regfile (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .halt     (halt),
        .st       (st_if),
        .wb_en    (wb_en),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .in_reset (in_reset)
    );

    rv_alu u_alu (
        .st           (st_if),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    rv_lsu u_lsu (
        .st        (st_if),
        .halt      (halt),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .datai     (datai),
        .daddr     (daddr),
        .datao     (datao),
        .load_data (load_data),
        .be        (be),
        .wr        (wr),
        .rd        (rd)
    );

    rv_pc_ctrl u_pc_ctrl (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .halt         (halt),
        .in_reset     (in_reset),
        .branch_taken (branch_taken),
        .alu_result   (alu_result),
        .load_data    (load_data),
        .daddr        (daddr),      // jalr target comes from the lsu adder
        .st           (st_if),
        .iaddr        (iaddr),
        .wb_en        (wb_en),
        .wb_data      (wb_data),
        .idle         (idle)
    );

endmodule

// ==== source/rv_pc_ctrl.sv ====
// program counters, fetch address, flush slot and write-back value selection
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_pc_ctrl
    import rv_pkg::*;
(
    input  logic  CLK,
    input  logic  arst_n,
    input  logic  halt,
    input  logic  in_reset,
    input  logic  branch_taken,
    input  word_t alu_result,
    input  word_t load_data,
    input  word_t daddr,
    rv_stage_if.producer st,
    output word_t iaddr,
    output logic  wb_en,
    output word_t wb_data,
    output logic  idle
);

    word_t nxpc;     // sequential fetch address
    word_t pc_dec;   // address of the word now on idata
    word_t pcsimm;   // pc-relative target
    word_t jval;
    logic  jreq;
    logic  flush;    // next slot is a shadow or reset slot

    assign pcsimm = st.pc + st.instr.simm;
    assign jreq   = (st.valid && (st.instr.is_jal || st.instr.is_jalr)) || branch_taken;
    assign jval   = st.instr.is_jalr ? {daddr[31:1], 1'b0} : pcsimm; // jalr drops bit 0

    // redirect goes straight to the rom so only one shadow slot exists
    assign iaddr = in_reset ? `RV_RESET_PC : (jreq ? jval : nxpc);

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            nxpc   <= `RV_RESET_PC;
            pc_dec <= `RV_RESET_PC;
            st.pc  <= `RV_RESET_PC;
            flush  <= 1'b1;
        end
        else if (in_reset || !halt)
        begin
            pc_dec <= iaddr;          // rom answers this one a cycle later
            nxpc   <= iaddr + 32'd4;
            st.pc  <= pc_dec;
            flush  <= in_reset || jreq;
        end
    end

    assign st.valid = !flush;
    assign idle     = flush;

    assign wb_en = st.valid && (st.instr.is_lui || st.instr.is_auipc || st.instr.is_jal ||
                                st.instr.is_jalr || st.instr.is_load ||
                                st.instr.is_op_imm || st.instr.is_op_reg);

    always_comb
    begin
        if (st.instr.is_auipc)
            wb_data = pcsimm;
        else if (st.instr.is_jal || st.instr.is_jalr)
            wb_data = st.pc + 32'd4;   // link
        else if (st.instr.is_lui)
            wb_data = st.instr.simm;
        else if (st.instr.is_load)
            wb_data = load_data;
        else
            wb_data = alu_result;
    end

endmodule

// ==== source/rv_lsu.sv ====
// data-bus side of execute: effective address, byte enables, store lanes and load extraction
`timescale 1ns/1ps

module rv_lsu
    import rv_pkg::*;
(
    rv_stage_if.consumer st,
    input  logic     halt,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    datai,
    output word_t    daddr,
    output word_t    datao,
    output word_t    load_data,
    output logic [3:0] be,
    output logic     wr,
    output logic     rd
);

    logic [4:0] lane_sh;   // byte offset as a bit shift
    word_t      lane_byte; // addressed byte moved down to bits 7:0
    logic [15:0] half;     // addressed halfword
    mem_f3_t    size;

    assign daddr     = rs1_data + st.instr.simm; // also the jalr target
    assign size      = mem_f3_t'(st.instr.funct3);
    assign lane_sh   = {daddr[1:0], 3'b000};
    assign lane_byte = datai >> lane_sh;
    assign half      = daddr[1] ? datai[31:16] : datai[15:0];

    always_comb
    begin
        case (size)
            mem_b, mem_bu:
            begin
                be    = 4'b0001 << daddr[1:0];                 // one lane
                datao = {24'b0, rs2_data[7:0]} << lane_sh;     // other lanes zero
            end
            mem_h, mem_hu:
            begin
                be    = daddr[1] ? 4'b1100 : 4'b0011;
                datao = daddr[1] ? {rs2_data[15:0], 16'b0} : {16'b0, rs2_data[15:0]};
            end
            default:
            begin
                be    = 4'b1111;  // word
                datao = rs2_data;
            end
        endcase
    end

    always_comb
    begin
        case (size)
            mem_b:   load_data = {{24{lane_byte[7]}}, lane_byte[7:0]};
            mem_bu:  load_data = {24'b0, lane_byte[7:0]};
            mem_h:   load_data = {{16{half[15]}}, half};
            mem_hu:  load_data = {16'b0, half};
            default: load_data = datai;
        endcase
    end

    // one-cycle strobes, none in a flush slot or a halted cycle
    assign wr = st.valid && st.instr.is_store && !halt;
    assign rd = st.valid && st.instr.is_load && !halt;

endmodule

// ==== source/rv_alu.sv ====
// integer ALU for register and immediate forms plus the conditional-branch compare
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    rv_stage_if.consumer st,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t alu_result,
    output logic  branch_taken
);

    word_t      opb;     // second operand
    logic [4:0] shamt;
    logic       lt_s;    // signed rs1 < opb
    logic       lt_u;
    logic       b_eq;    // branch compares always use rs2
    logic       b_lt_s;
    logic       b_lt_u;
    logic       cond;

    assign opb   = st.instr.is_op_imm ? st.instr.simm : rs2_data;
    assign shamt = st.instr.is_op_imm ? st.instr.uimm[4:0] : rs2_data[4:0]; // shamt is unsigned
    assign lt_s  = $signed(rs1_data) < $signed(opb);
    assign lt_u  = rs1_data < opb;     // sltiu compares the sign-extended imm unsigned

    assign b_eq   = (rs1_data == rs2_data);
    assign b_lt_s = $signed(rs1_data) < $signed(rs2_data);
    assign b_lt_u = rs1_data < rs2_data;

    always_comb
    begin
        case (alu_f3_t'(st.instr.funct3))
            alu_add:
                // sub only exists in the register form, addi has bit 30 as imm
                alu_result = (st.instr.is_op_reg && st.instr.alt) ? rs1_data - opb
                                                                  : rs1_data + opb;
            alu_sll:  alu_result = rs1_data << shamt;
            alu_slt:  alu_result = {31'b0, lt_s};
            alu_sltu: alu_result = {31'b0, lt_u};
            alu_xor:  alu_result = rs1_data ^ opb;
            alu_sr:
                alu_result = st.instr.alt ? word_t'($signed(rs1_data) >>> shamt) // sra
                                          : rs1_data >> shamt;                  // srl
            alu_or:   alu_result = rs1_data | opb;
            alu_and:  alu_result = rs1_data & opb;
            default:  alu_result = rs1_data + opb;
        endcase
    end

    always_comb
    begin
        case (br_f3_t'(st.instr.funct3))
            br_beq:  cond = b_eq;
            br_bne:  cond = !b_eq;
            br_blt:  cond = b_lt_s;
            br_bge:  cond = !b_lt_s;
            br_bltu: cond = b_lt_u;
            br_bgeu: cond = !b_lt_u;
            default: cond = 1'b0;  // 2 and 3 are not branches
        endcase
    end

    // only a live branch slot may redirect
    assign branch_taken = st.valid && st.instr.is_branch && cond;

endmodule

// ==== source/rv_regfile.sv ====
// 32x32 register file with two combinational reads, one write port and the counted reset fill
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic  CLK,
    input  logic  arst_n,
    input  logic  halt,
    rv_stage_if.consumer st,
    input  logic  wb_en,
    input  word_t wb_data,
    output word_t rs1_data,
    output word_t rs2_data,
    output logic  in_reset
);

    word_t    regs [`RV_NREGS]; // architectural registers
    reg_idx_t rst_cnt;          // runs 31 down to 0 after arst_n
    word_t    rst_val;

    assign in_reset = |rst_cnt;                                 // counting
    assign rst_val  = (rst_cnt == 5'd2) ? `RV_RESET_SP : '0;   // sp gets the stack top

    // x0 reads as zero, its entry is never written
    assign rs1_data = (st.instr.rs1 == '0) ? '0 : regs[st.instr.rs1];
    assign rs2_data = (st.instr.rs2 == '0) ? '0 : regs[st.instr.rs2];

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
            rst_cnt <= 5'd31;
        else if (in_reset)
            rst_cnt <= rst_cnt - 5'd1; // one register per cycle
    end

    always_ff @(posedge CLK)
    begin
        if (in_reset)
            regs[rst_cnt] <= rst_val;              // x31 down to x1
        else if (wb_en && !halt && st.instr.rd != '0)
            regs[st.instr.rd] <= wb_data;
    end

endmodule

// ==== source/rv_predecode.sv ====
// first pipeline stage: registers the fetched word as opcode flags, register fields and immediates
`timescale 1ns/1ps

module rv_predecode
    import rv_pkg::*;
(
    input  logic  CLK,
    input  logic  arst_n,
    input  logic  halt,
    input  logic  in_reset,
    input  word_t idata,
    rv_stage_if.stage st
);

    logic       frozen;    // halted outside the reset count
    logic       hold_q;    // previous cycle was frozen
    word_t      hold_buf;  // fetched word caught on the first frozen cycle
    word_t      word;      // word presented to the decoder
    opcode_t    opc;
    dec_instr_t dec_n;

    assign frozen = halt && !in_reset;

    // rom keeps sampling iaddr while frozen, so the word seen on entry is kept aside
    assign word = hold_q ? hold_buf : idata;
    assign opc  = opcode_t'(word[6:0]);

    always_comb
    begin
        dec_n           = '0;
        dec_n.is_lui    = (opc == opc_lui);    // one compare per group
        dec_n.is_auipc  = (opc == opc_auipc);
        dec_n.is_jal    = (opc == opc_jal);
        dec_n.is_jalr   = (opc == opc_jalr);
        dec_n.is_branch = (opc == opc_branch);
        dec_n.is_load   = (opc == opc_load);
        dec_n.is_store  = (opc == opc_store);
        dec_n.is_op_imm = (opc == opc_op_imm);
        dec_n.is_op_reg = (opc == opc_op_reg);
        dec_n.rd        = word[11:7];
        dec_n.rs1       = word[19:15];
        dec_n.rs2       = word[24:20];
        dec_n.funct3    = word[14:12];
        dec_n.alt       = word[30];           // sub / sra select
        case (opc)
            opc_store:
            begin
                dec_n.simm = {{20{word[31]}}, word[31:25], word[11:7]}; // s-type
                dec_n.uimm = {20'b0, word[31:25], word[11:7]};
            end
            opc_branch:
            begin
                dec_n.simm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
                dec_n.uimm = {19'b0, word[31], word[7], word[30:25], word[11:8], 1'b0};
            end
            opc_jal:
            begin
                dec_n.simm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
                dec_n.uimm = {11'b0, word[31], word[19:12], word[20], word[30:21], 1'b0};
            end
            opc_lui, opc_auipc:
            begin
                dec_n.simm = {word[31:12], 12'b0}; // u-type, same both ways
                dec_n.uimm = {word[31:12], 12'b0};
            end
            default:
            begin
                dec_n.simm = {{20{word[31]}}, word[31:20]}; // i-type
                dec_n.uimm = {20'b0, word[31:20]};
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            st.instr <= '0;
            hold_q   <= 1'b0;
        end
        else
        begin
            hold_q <= frozen;
            if (in_reset)
                st.instr <= '0;    // no flags while counting down
            else if (!halt)
                st.instr <= dec_n;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (frozen && !hold_q)
            hold_buf <= idata;  // word for the address fetched before the freeze
    end

endmodule

// ==== source/rv_stage_if.sv ====
// decoded-slot bundle between pre-decode and execute, with producer, stage and consumer views
`timescale 1ns/1ps

interface rv_stage_if
    import rv_pkg::*;
();

    dec_instr_t instr; // registered by pre-decode
    logic       valid; // low in a flush slot
    word_t      pc;    // address of the executing instruction

    // pc control owns the address and the flush state
    modport producer (
        output pc,
        output valid,
        input  instr
    );

    // pre-decode fills the instruction
    modport stage (
        output instr
    );

    // execute side reads everything
    modport consumer (
        input instr,
        input valid,
        input pc
    );

endinterface

// ==== source/rv_pkg.sv ====
// core types shared by the RTL: word and index types, opcode and funct3 encodings, decoded slot
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;   // one data/address word
    typedef logic [`RV_REGW-1:0] reg_idx_t; // register index

    // major opcodes of the kept groups
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op_reg = 7'b0110011
    } opcode_t;

    // alu funct3, add doubles as sub and sr as srl/sra via the alt bit
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sll  = 3'd1,
        alu_slt  = 3'd2,
        alu_sltu = 3'd3,
        alu_xor  = 3'd4,
        alu_sr   = 3'd5,
        alu_or   = 3'd6,
        alu_and  = 3'd7
    } alu_f3_t;

    typedef enum logic [2:0] {
        mem_b  = 3'd0,
        mem_h  = 3'd1,
        mem_w  = 3'd2,
        mem_bu = 3'd4,
        mem_hu = 3'd5
    } mem_f3_t;

    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd4,
        br_bge  = 3'd5,
        br_bltu = 3'd6,
        br_bgeu = 3'd7
    } br_f3_t;

    // one pre-decoded instruction, flags first, immediates last
    typedef struct packed {
        logic     is_lui;
        logic     is_auipc;
        logic     is_jal;
        logic     is_jalr;
        logic     is_branch;
        logic     is_load;
        logic     is_store;
        logic     is_op_imm;
        logic     is_op_reg;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [2:0] funct3;
        logic     alt;    // funct7 bit 5
        word_t    simm;   // sign-extended immediate
        word_t    uimm;   // zero-extended immediate
    } dec_instr_t;

endpackage

// ==== source/rv_macros.svh ====
// width, register count and reset constants, included by the package and the RTL files that use them
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers and their index width
`define RV_NREGS 32
`define RV_REGW 5

// first fetch address once the reset count ends
`define RV_RESET_PC 32'h0000_0000

// loaded into x2 by the reset sequence
`define RV_RESET_SP 32'd4096

`endif
